// ==== Bender.yml ====
package:
  name: core_fe

sources:
  - include_dirs:
      - common
    files:
      - common/fe_pkg.sv
      - hw/pipe_stage.sv
      - hw/fetch/imem_rom.sv
      - hw/decode/inst_decode.sv
      - hw/target_calc.sv
      - hw/retire_stage.sv
      - hw/core_fe_top.sv
      - verif/core_fe_chk.sv
      - verif/core_fe_tb.sv

// ==== common/fe_defs.svh ====
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// data and address width
`define FE_XLEN 32

// instruction rom size
`define FE_ROM_DEPTH 16

// word address bits that index the rom
`define FE_ROM_IDX_LO 2
`define FE_ROM_IDX_HI 5

// retire sequence counter width
`define FE_SEQ_W 16

`endif

// ==== common/fe_pkg.sv ====
`include "fe_defs.svh"

package fe_pkg;

    // anything without a listed opcode decodes to cls_other
    typedef enum logic [3:0] {
        cls_alu_reg = 4'd0,
        cls_alu_imm = 4'd1,
        cls_load    = 4'd2,
        cls_store   = 4'd3,
        cls_branch  = 4'd4,
        cls_jal     = 4'd5,
        cls_lui     = 4'd6,
        cls_auipc   = 4'd7,
        cls_system  = 4'd8,
        cls_other   = 4'd9
    } inst_class_e;

    // fetch stage payload
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] inst;
    } fetch_t;

    // pre-decoded instruction
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] inst; // raw word kept for the retire record
        inst_class_e         cls;
        logic [4:0]          rd;
        logic [`FE_XLEN-1:0] imm;  // sign-extended
    } decode_t;

    // decode fields plus static target
    typedef struct packed {
        decode_t             dec;
        logic [`FE_XLEN-1:0] target;
    } exec_t;

endpackage

// ==== hw/core_fe_top.sv ====
`include "fe_defs.svh"

module core_fe_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  logic                 req_valid_i,
    input  logic [`FE_XLEN-1:0]  req_addr_i,
    output logic                 req_ready_o,
    output logic                 ret_valid_o,
    input  logic                 ret_ready_i,
    output logic [`FE_XLEN-1:0]  ret_addr_o,
    output logic [`FE_XLEN-1:0]  ret_inst_o,
    output fe_pkg::inst_class_e  ret_class_o,
    output logic [4:0]           ret_rd_o,
    output logic [`FE_XLEN-1:0]  ret_imm_o,
    output logic [`FE_XLEN-1:0]  ret_target_o,
    output logic [`FE_SEQ_W-1:0] ret_seq_o
);

    logic            fetch_valid;
    logic            fetch_ready;
    fe_pkg::fetch_t  fetch_data;
    logic            dec_valid;
    logic            dec_ready;
    fe_pkg::decode_t dec_data;
    logic            exec_valid;
    logic            exec_ready;
    fe_pkg::exec_t   exec_data;

    imem_rom u_imem_rom (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_ready_o (req_ready_o),
        .out_valid_o (fetch_valid),
        .out_data_o  (fetch_data),
        .out_ready_i (fetch_ready)
    );

    inst_decode u_inst_decode (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (fetch_valid),
        .in_data_i   (fetch_data),
        .in_ready_o  (fetch_ready),
        .out_valid_o (dec_valid),
        .out_data_o  (dec_data),
        .out_ready_i (dec_ready)
    );

    target_calc u_target_calc (
        .in_valid_i  (dec_valid),
        .in_data_i   (dec_data),
        .in_ready_o  (dec_ready),
        .out_valid_o (exec_valid),
        .out_data_o  (exec_data),
        .out_ready_i (exec_ready)
    );

    retire_stage u_retire_stage (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .in_valid_i   (exec_valid),
        .in_data_i    (exec_data),
        .in_ready_o   (exec_ready),
        .ret_valid_o  (ret_valid_o),
        .ret_ready_i  (ret_ready_i),
        .ret_addr_o   (ret_addr_o),
        .ret_inst_o   (ret_inst_o),
        .ret_class_o  (ret_class_o),
        .ret_rd_o     (ret_rd_o),
        .ret_imm_o    (ret_imm_o),
        .ret_target_o (ret_target_o),
        .ret_seq_o    (ret_seq_o)
    );

endmodule

// ==== hw/decode/inst_decode.sv ====
`include "fe_defs.svh"

module inst_decode (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush_i,
    input  logic            in_valid_i,
    input  fe_pkg::fetch_t  in_data_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output fe_pkg::decode_t out_data_o,
    input  logic            out_ready_i
);

    localparam logic [6:0] OP_ALU_REG = 7'b0110011;
    localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_JAL     = 7'b1101111;
    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_AUIPC   = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

    logic [`FE_XLEN-1:0] inst;
    logic [`FE_XLEN-1:0] i_imm;
    logic [`FE_XLEN-1:0] s_imm;
    logic [`FE_XLEN-1:0] b_imm;
    logic [`FE_XLEN-1:0] j_imm;
    logic [`FE_XLEN-1:0] u_imm;
    fe_pkg::decode_t     dec_d;

    assign inst = in_data_i.inst;

    assign i_imm = {{(`FE_XLEN-12){inst[31]}}, inst[31:20]};
    assign s_imm = {{(`FE_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{(`FE_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign j_imm = {{(`FE_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};

    always_comb begin
        dec_d.pc   = in_data_i.pc;
        dec_d.inst = inst;
        dec_d.rd   = inst[11:7]; // raw field, meaningless for store and branch
        case (inst[6:0])
            OP_ALU_REG: dec_d.cls = fe_pkg::cls_alu_reg;
            OP_ALU_IMM: dec_d.cls = fe_pkg::cls_alu_imm;
            OP_LOAD:    dec_d.cls = fe_pkg::cls_load;
            OP_STORE:   dec_d.cls = fe_pkg::cls_store;
            OP_BRANCH:  dec_d.cls = fe_pkg::cls_branch;
            OP_JAL:     dec_d.cls = fe_pkg::cls_jal;
            OP_LUI:     dec_d.cls = fe_pkg::cls_lui;
            OP_AUIPC:   dec_d.cls = fe_pkg::cls_auipc;
            OP_SYSTEM:  dec_d.cls = fe_pkg::cls_system;
            default:    dec_d.cls = fe_pkg::cls_other;
        endcase
        case (dec_d.cls)
            fe_pkg::cls_alu_imm,
            fe_pkg::cls_load,
            fe_pkg::cls_system: dec_d.imm = i_imm;
            fe_pkg::cls_store:  dec_d.imm = s_imm;
            fe_pkg::cls_branch: dec_d.imm = b_imm;
            fe_pkg::cls_jal:    dec_d.imm = j_imm;
            fe_pkg::cls_lui,
            fe_pkg::cls_auipc:  dec_d.imm = u_imm;
            default:            dec_d.imm = '0;
        endcase
    end

    pipe_stage #(
        .payload_t (fe_pkg::decode_t)
    ) u_dec_stage (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (dec_d),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== hw/fetch/imem_rom.sv ====
`include "fe_defs.svh"

module imem_rom (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush_i,
    input  logic                req_valid_i,
    input  logic [`FE_XLEN-1:0] req_addr_i,
    output logic                req_ready_o,
    output logic                out_valid_o,
    output fe_pkg::fetch_t      out_data_o,
    input  logic                out_ready_i
);

    logic [`FE_XLEN-1:0] addr_q;
    logic                addr_valid;
    logic                addr_ready;
    logic [`FE_XLEN-1:0] rom_mem [`FE_ROM_DEPTH];
    fe_pkg::fetch_t      fetch_d;

    // first stage holds the request address
    pipe_stage #(
        .payload_t (logic [`FE_XLEN-1:0])
    ) u_req_stage (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (req_valid_i),
        .in_data_i   (req_addr_i),
        .in_ready_o  (req_ready_o),
        .out_valid_o (addr_valid),
        .out_data_o  (addr_q),
        .out_ready_i (addr_ready)
    );

    // fixed test program, rest is nop
    always_comb begin
        for (int i = 0; i < `FE_ROM_DEPTH; i++) begin
            rom_mem[i] = 32'h0000_0013;
        end
        rom_mem[0]  = 32'h0f00_0537; // lui   a0,0xf000
        rom_mem[1]  = 32'h0000_1297; // auipc t0,0x1
        rom_mem[2]  = 32'h0020_0593; // addi  a1,zero,2
        rom_mem[3]  = 32'h00b5_2223; // sw    a1,4(a0)
        rom_mem[4]  = 32'h0045_2303; // lw    t1,4(a0)
        rom_mem[5]  = 32'h00b3_03b3; // add   t2,t1,a1
        rom_mem[6]  = 32'h4053_83b3; // sub   t2,t2,t0
        rom_mem[7]  = 32'hfe03_9ce3; // bne   t2,zero,-8
        rom_mem[8]  = 32'h00c0_00ef; // jal   ra,+12
        rom_mem[9]  = 32'hfff4_0413; // addi  s0,s0,-1
        rom_mem[10] = 32'h0010_0073; // ebreak
    end

    assign fetch_d.pc   = addr_q;
    assign fetch_d.inst = rom_mem[addr_q[`FE_ROM_IDX_HI:`FE_ROM_IDX_LO]];

    // second stage holds pc and instruction
    pipe_stage #(
        .payload_t (fe_pkg::fetch_t)
    ) u_fetch_stage (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (addr_valid),
        .in_data_i   (fetch_d),
        .in_ready_o  (addr_ready),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== hw/pipe_stage.sv ====
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    logic     idle;
    payload_t data_q;
    logic     in_fire;
    logic     out_fire;

    assign in_fire  = in_valid_i && in_ready_o;
    assign out_fire = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            idle <= 1'b1;
        end else if (flush_i) begin
            idle <= 1'b1; // drop whatever is held
        end else if (in_fire) begin
            idle <= 1'b0;
        end else if (out_fire) begin
            idle <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            data_q <= in_data_i;
        end
    end

    // refill in the same cycle the entry leaves
    assign in_ready_o  = idle || out_fire || flush_i;
    assign out_valid_o = !idle && !flush_i;
    assign out_data_o  = data_q;

endmodule

// ==== hw/retire_stage.sv ====
`include "fe_defs.svh"

module retire_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  logic                 in_valid_i,
    input  fe_pkg::exec_t        in_data_i,
    output logic                 in_ready_o,
    output logic                 ret_valid_o,
    input  logic                 ret_ready_i,
    output logic [`FE_XLEN-1:0]  ret_addr_o,
    output logic [`FE_XLEN-1:0]  ret_inst_o,
    output fe_pkg::inst_class_e  ret_class_o,
    output logic [4:0]           ret_rd_o,
    output logic [`FE_XLEN-1:0]  ret_imm_o,
    output logic [`FE_XLEN-1:0]  ret_target_o,
    output logic [`FE_SEQ_W-1:0] ret_seq_o
);

    fe_pkg::exec_t        ret_q;
    logic [`FE_SEQ_W-1:0] seq_q;

    pipe_stage #(
        .payload_t (fe_pkg::exec_t)
    ) u_ret_stage (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (ret_valid_o),
        .out_data_o  (ret_q),
        .out_ready_i (ret_ready_i)
    );

    // counts retire transfers, flush leaves it alone
    always_ff @(posedge clk) begin
        if (reset) begin
            seq_q <= '0;
        end else if (ret_valid_o && ret_ready_i) begin
            seq_q <= seq_q + 1'b1;
        end
    end

    assign ret_addr_o   = ret_q.dec.pc;
    assign ret_inst_o   = ret_q.dec.inst;
    assign ret_class_o  = ret_q.dec.cls;
    assign ret_rd_o     = ret_q.dec.rd;
    assign ret_imm_o    = ret_q.dec.imm;
    assign ret_target_o = ret_q.target;
    assign ret_seq_o    = seq_q;

endmodule

// ==== hw/target_calc.sv ====
`include "fe_defs.svh"

module target_calc (
    input  logic            in_valid_i,
    input  fe_pkg::decode_t in_data_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output fe_pkg::exec_t   out_data_o,
    input  logic            out_ready_i
);

    logic [`FE_XLEN-1:0] op_a;
    logic [`FE_XLEN-1:0] op_b;
    logic                use_imm;
    logic                zero_base;

    // classes whose target is built from the immediate
    always_comb begin
        case (in_data_i.cls)
            fe_pkg::cls_branch,
            fe_pkg::cls_jal,
            fe_pkg::cls_lui,
            fe_pkg::cls_auipc: use_imm = 1'b1;
            default:           use_imm = 1'b0;
        endcase
    end

    assign zero_base = (in_data_i.cls == fe_pkg::cls_lui);

    // single adder, operands picked by class
    assign op_a = zero_base ? '0 : in_data_i.pc;
    assign op_b = use_imm ? in_data_i.imm : `FE_XLEN'd4;

    assign out_data_o.dec    = in_data_i;
    assign out_data_o.target = op_a + op_b;

    // no storage here, handshake passes straight through
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

endmodule

// ==== src.f ====
+incdir+common
common/fe_pkg.sv
hw/pipe_stage.sv
hw/fetch/imem_rom.sv
hw/decode/inst_decode.sv
hw/target_calc.sv
hw/retire_stage.sv
hw/core_fe_top.sv
verif/core_fe_chk.sv
verif/core_fe_tb.sv

// ==== verif/core_fe_chk.sv ====
`include "fe_defs.svh"

module core_fe_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 flush_i,
    input logic                 req_ready_o,
    input logic                 ret_valid_o,
    input logic                 ret_ready_i,
    input logic [`FE_XLEN-1:0]  ret_addr_o,
    input logic [`FE_XLEN-1:0]  ret_inst_o,
    input logic [`FE_XLEN-1:0]  ret_target_o,
    input logic [`FE_SEQ_W-1:0] ret_seq_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // stalled record holds until taken or flushed
    ret_stall_stable: assert property (@(posedge clk) disable iff (reset)
        ret_valid_o && !ret_ready_i |=> flush_i || (ret_valid_o && $stable(ret_addr_o)
            && $stable(ret_inst_o) && $stable(ret_target_o)))
    else begin
        fail_cnt++;
        $error("retire record changed while stalled");
    end

    reset_idle: assert property (@(posedge clk)
        reset |=> !ret_valid_o && req_ready_o && ret_seq_o == '0)
    else begin
        fail_cnt++;
        $error("front end not idle after reset");
    end

    // one step per retire transfer, otherwise held
    seq_step: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> ret_seq_o == $past(ret_seq_o) + $past(ret_valid_o && ret_ready_i))
    else begin
        fail_cnt++;
        $error("ret_seq_o did not follow retire transfers");
    end

endmodule

bind core_fe_top core_fe_chk u_fe_chk (.*);

// ==== verif/core_fe_tb.sv ====
`include "fe_defs.svh"

module core_fe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS    = 20;
    localparam int TIMEOUT_CYC = NUM_ROWS * 8 + 50;

    typedef struct {
        logic [`FE_XLEN-1:0] addr;
        logic                flush;  // flush cycle before this request
        logic                rnd;    // random ret_ready stalls
        logic [`FE_XLEN-1:0] inst;
        fe_pkg::inst_class_e cls;
        logic [4:0]          rd;
        logic [`FE_XLEN-1:0] imm;
        logic [`FE_XLEN-1:0] target;
    } row_t;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 flush_i = 1'b0;
    logic                 req_valid_i = 1'b0;
    logic [`FE_XLEN-1:0]  req_addr_i = '0;
    logic                 req_ready_o;
    logic                 ret_valid_o;
    logic                 ret_ready_i = 1'b1;
    logic [`FE_XLEN-1:0]  ret_addr_o;
    logic [`FE_XLEN-1:0]  ret_inst_o;
    fe_pkg::inst_class_e  ret_class_o;
    logic [4:0]           ret_rd_o;
    logic [`FE_XLEN-1:0]  ret_imm_o;
    logic [`FE_XLEN-1:0]  ret_target_o;
    logic [`FE_SEQ_W-1:0] ret_seq_o;

    row_t                 rows [NUM_ROWS];
    int                   row_cnt = 0;
    int                   cur_row = 0;
    logic                 stall_mode = 1'b0;
    logic                 stall_now;
    integer               seed = 32'hc196_261f;
    int                   cycle_cnt = 0;
    int                   stall_cnt = 0;
    int                   err_cnt = 0;
    int                   retired = 0;
    int                   dropped = 0;
    logic [`FE_SEQ_W-1:0] exp_seq = '0;
    int                   pend_row_q [$];   // expected records in request order
    int                   pend_cyc_q [$];
    int                   pend_stall_q [$];

    core_fe_top u_core_fe_top (.*);

    always #2 clk = ~clk;

    // stall choice made at the edge and driven just after it
    always @(posedge clk) begin
        stall_now = stall_mode && ($random(seed) & 1);
        #1 ret_ready_i = !stall_now;
    end

    task automatic add_row(input logic [31:0] addr, input int flush, input int rnd,
                           input logic [31:0] inst, input fe_pkg::inst_class_e cls,
                           input int rd, input logic [31:0] imm, input logic [31:0] target);
        rows[row_cnt] = '{addr, flush != 0, rnd != 0, inst, cls, 5'(rd), imm, target};
        row_cnt++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: t=%0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic score_retire();
        int r;
        int cyc;
        int stl;
        if (pend_row_q.size() == 0) begin
            $display("Error: t=%0t retire seen with no request pending", $time);
            err_cnt++;
        end else begin
            r   = pend_row_q.pop_front();
            cyc = pend_cyc_q.pop_front();
            stl = pend_stall_q.pop_front();
            compare_field("ret_addr_o", ret_addr_o, rows[r].addr);
            compare_field("ret_inst_o", ret_inst_o, rows[r].inst);
            compare_field("ret_class_o", 32'(ret_class_o), 32'(rows[r].cls));
            compare_field("ret_rd_o", 32'(ret_rd_o), 32'(rows[r].rd));
            compare_field("ret_imm_o", ret_imm_o, rows[r].imm);
            compare_field("ret_target_o", ret_target_o, rows[r].target);
            compare_field("ret_seq_o", 32'(ret_seq_o), 32'(exp_seq));
            if (stl == stall_cnt) begin // no stall since acceptance
                compare_field("retire latency", 32'(cycle_cnt - cyc), 32'd4);
            end
            exp_seq++;
            retired++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && flush_i) begin
            dropped += pend_row_q.size();
            pend_row_q.delete();
            pend_cyc_q.delete();
            pend_stall_q.delete();
        end
        if (!reset && ret_valid_o && ret_ready_i) begin
            score_retire();
        end
        if (!reset && !flush_i && req_valid_i && req_ready_o) begin
            pend_row_q.push_back(cur_row);
            pend_cyc_q.push_back(cycle_cnt);
            pend_stall_q.push_back(stall_cnt);
        end
        if (!ret_ready_i) begin
            stall_cnt++;
        end
        cycle_cnt++;
    end

    initial begin
        add_row('h00, 0, 0, 'h0f000537, fe_pkg::cls_lui,     10, 'h0f000000, 'h0f000000);
        add_row('h04, 0, 0, 'h00001297, fe_pkg::cls_auipc,    5, 'h00001000, 'h00001004);
        add_row('h08, 0, 0, 'h00200593, fe_pkg::cls_alu_imm, 11, 'h00000002, 'h0000000c);
        add_row('h0c, 0, 0, 'h00b52223, fe_pkg::cls_store,    4, 'h00000004, 'h00000010);
        add_row('h10, 0, 0, 'h00452303, fe_pkg::cls_load,     6, 'h00000004, 'h00000014);
        add_row('h14, 0, 0, 'h00b303b3, fe_pkg::cls_alu_reg,  7, 'h00000000, 'h00000018);
        add_row('h18, 0, 0, 'h405383b3, fe_pkg::cls_alu_reg,  7, 'h00000000, 'h0000001c);
        add_row('h1c, 0, 0, 'hfe039ce3, fe_pkg::cls_branch,  25, 'hfffffff8, 'h00000014);
        add_row('h20, 0, 1, 'h00c000ef, fe_pkg::cls_jal,      1, 'h0000000c, 'h0000002c);
        add_row('h24, 0, 1, 'hfff40413, fe_pkg::cls_alu_imm,  8, 'hffffffff, 'h00000028);
        add_row('h28, 0, 1, 'h00100073, fe_pkg::cls_system,   0, 'h00000001, 'h0000002c);
        add_row('h2c, 0, 1, 'h00000013, fe_pkg::cls_alu_imm,  0, 'h00000000, 'h00000030);
        add_row('h30, 0, 1, 'h00000013, fe_pkg::cls_alu_imm,  0, 'h00000000, 'h00000034);
        add_row('h34, 0, 1, 'h00000013, fe_pkg::cls_alu_imm,  0, 'h00000000, 'h00000038);
        add_row('h38, 0, 1, 'h00000013, fe_pkg::cls_alu_imm,  0, 'h00000000, 'h0000003c);
        add_row('h3c, 0, 1, 'h00000013, fe_pkg::cls_alu_imm,  0, 'h00000000, 'h00000040);
        add_row('h44, 1, 0, 'h00001297, fe_pkg::cls_auipc,    5, 'h00001000, 'h00001044);
        add_row('h5c, 0, 0, 'hfe039ce3, fe_pkg::cls_branch,  25, 'hfffffff8, 'h00000054);
        add_row('h60, 0, 0, 'h00c000ef, fe_pkg::cls_jal,      1, 'h0000000c, 'h0000006c);
        add_row('h40, 0, 0, 'h0f000537, fe_pkg::cls_lui,     10, 'h0f000000, 'h0f000000);
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        compare_field("ret_valid_o", 32'(ret_valid_o), 32'd0);
        compare_field("req_ready_o", 32'(req_ready_o), 32'd1);
        compare_field("ret_seq_o", 32'(ret_seq_o), 32'd0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            stall_mode = rows[i].rnd;
            if (rows[i].flush) begin
                flush_i = 1'b1;
                @(posedge clk);
                #1 flush_i = 1'b0;
            end
            cur_row     = i;
            req_addr_i  = rows[i].addr;
            req_valid_i = 1'b1;
            do begin
                @(posedge clk);
            end while (!req_ready_o);
            #1 req_valid_i = 1'b0;
        end
        stall_mode = 1'b0;
        while (pend_row_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk); // catch stray retires
        if (dropped == 0) begin
            $display("flush did not drop any request in flight");
            err_cnt++;
        end
        $display("errors: %0d, assertion failures: %0d, retired: %0d, dropped: %0d",
                 err_cnt, u_core_fe_top.u_fe_chk.fail_cnt, retired, dropped);
        if (err_cnt == 0 && u_core_fe_top.u_fe_chk.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYC) @(negedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("sim failed");
        $finish;
    end

endmodule
